/* Bender.yml */
package:
  name: snd_out

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - snd_pkg.sv
      - snd_ctrl_pkg.sv
      - snd_bus_if.sv
      - snd_ctrl.sv
      - pcm_format.sv
      - sd_dac.sv
      - snd_out_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_snd_out.sv

/* pcm_format.sv */
// sample conditioning, sample registers, mute level and mono mirroring
`timescale 1ns/1ps
`default_nettype none

`include "snd_defs.svh"

module pcm_format (
    input  wire logic          clk_dac,
    input  wire logic          rst,
    snd_bus_if.fmt             bus,
    input  wire snd_pkg::pcm_t snd_left_i,
    input  wire snd_pkg::pcm_t snd_right_i,
    input  wire logic          signed_i,
    output snd_pkg::pcm_wide_t sample_l_o,
    output snd_pkg::pcm_wide_t sample_r_o
);

    snd_pkg::pcm_t smp_left;
    snd_pkg::pcm_t smp_right;
    snd_pkg::pcm_t sel_left;
    snd_pkg::pcm_t sel_right;

    // two's complement to offset binary is an msb flip
    function automatic snd_pkg::pcm_t to_offset(input snd_pkg::pcm_t s, input logic sgn);
        to_offset = {s[`SND_PCM_W-1] ^ sgn, s[`SND_PCM_W-2:0]};
    endfunction

    // leading zero keeps the carry rate at most one half
    function automatic snd_pkg::pcm_wide_t pad(input snd_pkg::pcm_t s);
        pad = {{`SND_PAD_HI{1'b0}}, s, {`SND_PAD_LO{1'b0}}};
    endfunction

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            smp_left  <= `SND_MUTE_LEVEL;
            smp_right <= `SND_MUTE_LEVEL;
        end else if (bus.cen && bus.load) begin
            smp_left  <= to_offset(snd_left_i, signed_i);
            smp_right <= to_offset(snd_right_i, signed_i);
        end
    end

    always_comb begin
        sel_left  = bus.mute ? `SND_MUTE_LEVEL : smp_left;
        // mono takes the stored left sample
        if (bus.mute) begin
            sel_right = `SND_MUTE_LEVEL;
        end else begin
            sel_right = bus.mirror ? smp_left : smp_right;
        end
    end

    assign sample_l_o = pad(sel_left);
    assign sample_r_o = pad(sel_right);

endmodule

`default_nettype wire

/* sd_dac.sv */
// first-order sigma-delta modulator for one channel
`timescale 1ns/1ps
`default_nettype none

module sd_dac (
    input  wire logic               clk_dac,
    input  wire logic               rst,
    snd_bus_if.dac                  bus,
    input  wire snd_pkg::pcm_wide_t pcm_i,
    output logic                    pwm_o
);

    localparam int ACC_W = $bits(snd_pkg::sd_acc_t);

    snd_pkg::sd_acc_t acc;
    logic [ACC_W:0]   sum;

    // one extra bit to catch the carry
    assign sum = {1'b0, acc} + {1'b0, pcm_i};

    // carry rate equals pcm_i / 2^ACC_W
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            pwm_o <= 1'b0;
        end else if (bus.cen) begin
            acc   <= sum[ACC_W-1:0];
            pwm_o <= sum[ACC_W];
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
snd_pkg.sv
snd_ctrl_pkg.sv
snd_bus_if.sv
snd_ctrl.sv
pcm_format.sv
sd_dac.sv
snd_out_top.sv
tb_snd_out.sv

/* snd_bus_if.sv */
// interface carrying control strobes and levels to the sound datapath
`timescale 1ns/1ps
`default_nettype none

interface snd_bus_if;

    // one cycle in every SND_CEN_DIV
    logic cen;
    // capture strobe, cen qualified by the run state
    logic load;
    // present the mute level instead of stored samples
    logic mute;
    // right channel repeats the left
    logic mirror;

    modport ctrl (
        output cen,
        output load,
        output mute,
        output mirror
    );

    modport fmt (
        input cen,
        input load,
        input mute,
        input mirror
    );

    modport dac (
        input cen
    );

endinterface

`default_nettype wire

/* snd_ctrl.sv */
// sound controller with the enable ring and the run/mute FSM
`timescale 1ns/1ps
`default_nettype none

`include "snd_defs.svh"

module snd_ctrl (
    input  wire logic clk_dac,
    input  wire logic rst,
    input  wire logic mute_i,
    input  wire logic stereo_i,
    snd_bus_if.ctrl   bus
);

    localparam int CEN_DIV = `SND_CEN_DIV;
    // one hot, three rotations short of bit zero
    // so the first enable shows up at the third edge after reset
    localparam logic [CEN_DIV-1:0] RING_INIT = {{(CEN_DIV-2){1'b0}}, 2'b10};

    logic [CEN_DIV-1:0]        cen_ring;
    logic                      cen;
    snd_ctrl_pkg::ctrl_state_t state;
    snd_ctrl_pkg::ctrl_state_t state_nxt;
    snd_ctrl_pkg::out_mode_t   mode;

    assign cen = cen_ring[0];

    // rotating enable ring
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_ring <= RING_INIT;
        end else begin
            cen_ring <= {cen_ring[CEN_DIV-2:0], cen_ring[CEN_DIV-1]};
        end
    end

    // transitions only on the enable
    always_comb begin
        state_nxt = state;
        if (cen) begin
            case (state)
                snd_ctrl_pkg::ST_WAIT: begin
                    state_nxt = snd_ctrl_pkg::ST_RUN;
                end
                snd_ctrl_pkg::ST_RUN: begin
                    if (mute_i) begin
                        state_nxt = snd_ctrl_pkg::ST_MUTE;
                    end
                end
                snd_ctrl_pkg::ST_MUTE: begin
                    if (!mute_i) begin
                        state_nxt = snd_ctrl_pkg::ST_RUN;
                    end
                end
                default: begin
                    state_nxt = snd_ctrl_pkg::ST_WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            state <= snd_ctrl_pkg::ST_WAIT;
        end else begin
            state <= state_nxt;
        end
    end

    assign mode = stereo_i ? snd_ctrl_pkg::MODE_STEREO : snd_ctrl_pkg::MODE_MONO;

    assign bus.cen    = cen;
    assign bus.load   = cen && (state == snd_ctrl_pkg::ST_RUN);
    assign bus.mute   = (state != snd_ctrl_pkg::ST_RUN);
    assign bus.mirror = (mode == snd_ctrl_pkg::MODE_MONO);

endmodule

`default_nettype wire

/* snd_ctrl_pkg.sv */
// controller state enum and output-mode enum
`default_nettype none

package snd_ctrl_pkg;

    // run/mute sequencing, steps only on the modulator enable
    typedef enum logic [1:0] {
        ST_WAIT = 2'd0,
        ST_RUN  = 2'd1,
        ST_MUTE = 2'd2
    } ctrl_state_t;

    // right channel source
    typedef enum logic {
        MODE_STEREO = 1'b0,
        MODE_MONO   = 1'b1
    } out_mode_t;

endpackage

`default_nettype wire

/* snd_defs.svh */
// enable divider length, sample padding widths and mute level
`ifndef SND_DEFS_SVH
`define SND_DEFS_SVH

// clk_dac cycles per modulator enable
`define SND_CEN_DIV    4

// game sample width
`define SND_PCM_W      16

// zero bits added above and below the sample
`define SND_PAD_HI     1
`define SND_PAD_LO     3
`define SND_WIDE_W     (`SND_PAD_HI + `SND_PCM_W + `SND_PAD_LO)

// midscale in offset binary, a quarter density after padding
`define SND_MUTE_LEVEL 16'h8000

`endif

/* snd_out_top.sv */
// audio output top with controller, formatter and two modulators
`timescale 1ns/1ps
`default_nettype none

module snd_out_top (
    input  wire logic          clk_dac,
    input  wire logic          rst,
    input  wire logic          mute_i,
    input  wire logic          stereo_i,
    input  wire logic          signed_i,
    input  wire snd_pkg::pcm_t snd_left_i,
    input  wire snd_pkg::pcm_t snd_right_i,
    output wire logic          snd_pwm_left_o,
    output wire logic          snd_pwm_right_o
);

    snd_pkg::pcm_wide_t sample_l;
    snd_pkg::pcm_wide_t sample_r;

    snd_bus_if bus ();

    snd_ctrl u_ctrl (
        .clk_dac  ( clk_dac  ),
        .rst      ( rst      ),
        .mute_i   ( mute_i   ),
        .stereo_i ( stereo_i ),
        .bus      ( bus.ctrl )
    );

    pcm_format u_format (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .bus         ( bus.fmt     ),
        .snd_left_i  ( snd_left_i  ),
        .snd_right_i ( snd_right_i ),
        .signed_i    ( signed_i    ),
        .sample_l_o  ( sample_l    ),
        .sample_r_o  ( sample_r    )
    );

    sd_dac u_dac_left (
        .clk_dac ( clk_dac        ),
        .rst     ( rst            ),
        .bus     ( bus.dac        ),
        .pcm_i   ( sample_l       ),
        .pwm_o   ( snd_pwm_left_o )
    );

    sd_dac u_dac_right (
        .clk_dac ( clk_dac         ),
        .rst     ( rst             ),
        .bus     ( bus.dac         ),
        .pcm_i   ( sample_r        ),
        .pwm_o   ( snd_pwm_right_o )
    );

endmodule

`default_nettype wire

/* snd_pkg.sv */
// sample, padded sample and accumulator vector types
`default_nettype none

`include "snd_defs.svh"

package snd_pkg;

    // game sample as delivered by the core
    typedef logic [`SND_PCM_W-1:0] pcm_t;

    // leading zero, offset-binary sample, trailing zeros
    typedef logic [`SND_WIDE_W-1:0] pcm_wide_t;

    // first-order modulator state
    // same width as its input, the carry is the output bit
    typedef logic [`SND_WIDE_W-1:0] sd_acc_t;

endpackage

`default_nettype wire

/* tb_snd_out.sv */
// testbench for the audio output path with reference model and density checks
`timescale 1ns/1ps
`default_nettype none

`include "snd_defs.svh"

module tb_snd_out;

    localparam int WIN     = 2048;
    localparam int CEN_DIV = `SND_CEN_DIV;
    localparam int N_RAND  = 12;
    // reset mute, unsigned, signed, extremes, mute and release, mono
    localparam int N_WIN   = 1 + N_RAND + N_RAND + 1 + 2 + 1;
    localparam int LIMIT   = (3 * N_WIN * WIN) / 2;
    localparam int TOL     = 8;
    localparam int SETTLE  = 2 * CEN_DIV;
    // a mute release or reset needs one more load before the new sample reaches the DAC
    localparam int SETTLE_LONG = 4 * CEN_DIV;

    logic                      clk_dac = 1'b0;
    logic                      rst;
    logic                      mute;
    logic                      stereo;
    logic                      signed_mode;
    snd_pkg::pcm_t             snd_left;
    snd_pkg::pcm_t             snd_right;
    logic                      pwm_left;
    logic                      pwm_right;
    logic                      mono_chk = 1'b0;
    int                        cycle_cnt = 0;
    int                        seed = 32'h0d74_5346;
    snd_pkg::pcm_t             smp_l [N_RAND];
    snd_pkg::pcm_t             smp_r [N_RAND];
    snd_ctrl_pkg::ctrl_state_t st;

    snd_out_top dut0 (
        .clk_dac         ( clk_dac     ),
        .rst             ( rst         ),
        .mute_i          ( mute        ),
        .stereo_i        ( stereo      ),
        .signed_i        ( signed_mode ),
        .snd_left_i      ( snd_left    ),
        .snd_right_i     ( snd_right   ),
        .snd_pwm_left_o  ( pwm_left    ),
        .snd_pwm_right_o ( pwm_right   )
    );

    always #2 clk_dac = ~clk_dac;

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pcm_wide(input snd_pkg::sd_acc_t exp_cnt,
                                  input snd_pkg::sd_acc_t obs_cnt, input string what);
        if ((obs_cnt > exp_cnt + TOL) || (obs_cnt + TOL < exp_cnt)) begin
            report_mismatch($sformatf("%s high cycles %0d, expected %0d +/- %0d",
                                      what, obs_cnt, exp_cnt, TOL));
        end
    endtask

    task automatic check_level(input logic exp_lvl, input logic obs_lvl, input string what);
        if (obs_lvl !== exp_lvl) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, obs_lvl, exp_lvl));
        end
    endtask

    // padded offset-binary value the modulator should see
    function automatic snd_pkg::pcm_wide_t padded_ref(input snd_pkg::pcm_t smp,
                                                      input logic sgn, input logic muted);
        snd_pkg::pcm_t      ob;
        snd_pkg::pcm_wide_t w;
        if (muted) begin
            ob = `SND_MUTE_LEVEL;
        end else if (sgn) begin
            // adding half range turns two's complement into offset binary
            ob = smp + 16'h8000;
        end else begin
            ob = smp;
        end
        w = ob;
        return w << `SND_PAD_LO;
    endfunction

    // carries of a first-order loop over n_en enables from zero
    function automatic snd_pkg::sd_acc_t ones_for(input snd_pkg::pcm_wide_t x, input int n_en);
        longint           prod;
        snd_pkg::sd_acc_t ones;
        prod = x;
        prod = prod * n_en;
        ones = prod >> $bits(snd_pkg::sd_acc_t);
        return ones;
    endfunction

    task automatic apply_inputs(input snd_pkg::pcm_t left, input snd_pkg::pcm_t right,
                                input logic sgn, input logic st_mode, input logic mt);
        @(posedge clk_dac);
        snd_left    <= left;
        snd_right   <= right;
        signed_mode <= sgn;
        stereo      <= st_mode;
        mute        <= mt;
    endtask

    task automatic reset_dut();
        @(posedge clk_dac);
        rst <= 1'b1;
        repeat (3) @(posedge clk_dac);
        rst <= 1'b0;
    endtask

    task automatic measure_window(input snd_pkg::pcm_wide_t exp_l,
                                  input snd_pkg::pcm_wide_t exp_r,
                                  input int settle, input string label);
        snd_pkg::sd_acc_t hi_l;
        snd_pkg::sd_acc_t hi_r;
        snd_pkg::sd_acc_t exp_cl;
        snd_pkg::sd_acc_t exp_cr;
        repeat (settle) @(posedge clk_dac);
        hi_l = '0;
        hi_r = '0;
        repeat (WIN) begin
            @(negedge clk_dac);
            hi_l = hi_l + pwm_left;
            hi_r = hi_r + pwm_right;
        end
        // each carry holds the pin for one enable period
        exp_cl = CEN_DIV * ones_for(exp_l, WIN / CEN_DIV);
        exp_cr = CEN_DIV * ones_for(exp_r, WIN / CEN_DIV);
        check_pcm_wide(exp_cl, hi_l, {label, " left"});
        check_pcm_wide(exp_cr, hi_r, {label, " right"});
    endtask

    task automatic show_state(input string when);
        st = dut0.u_ctrl.state;
        $display("%s: controller in %s", when, st.name());
    endtask

    // mono outputs must match on every cycle
    always @(negedge clk_dac) begin
        if (mono_chk) begin
            check_level(pwm_left, pwm_right, "mono right output");
        end
    end

    always @(posedge clk_dac) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == LIMIT) begin
            $display("timeout: run did not finish within %0d clock cycles", LIMIT);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst         = 1'b1;
        mute        = 1'b1;
        stereo      = 1'b1;
        signed_mode = 1'b0;
        snd_left    = '0;
        snd_right   = '0;
        for (int i = 0; i < N_RAND; i++) begin
            smp_l[i] = $random(seed);
            smp_r[i] = $random(seed);
        end
        reset_dut();

        // quiet pins until the first enable, then mute density
        repeat (CEN_DIV - 1) begin
            @(negedge clk_dac);
            check_level(1'b0, pwm_left, "left pwm before first enable");
            check_level(1'b0, pwm_right, "right pwm before first enable");
        end
        measure_window(padded_ref('0, 1'b0, 1'b1), padded_ref('0, 1'b0, 1'b1), SETTLE,
                       "mute from reset");
        show_state("after reset window");

        for (int i = 0; i < N_RAND; i++) begin
            apply_inputs(smp_l[i], smp_r[i], 1'b0, 1'b1, 1'b0);
            measure_window(padded_ref(smp_l[i], 1'b0, 1'b0), padded_ref(smp_r[i], 1'b0, 1'b0),
                           (i == 0) ? SETTLE_LONG : SETTLE, $sformatf("unsigned sample %0d", i));
        end

        for (int i = 0; i < N_RAND; i++) begin
            apply_inputs(smp_l[i], smp_r[i], 1'b1, 1'b1, 1'b0);
            measure_window(padded_ref(smp_l[i], 1'b1, 1'b0), padded_ref(smp_r[i], 1'b1, 1'b0),
                           SETTLE, $sformatf("signed sample %0d", i));
        end
        // most negative gives no pulses, most positive nearly half
        apply_inputs(16'h8000, 16'h7fff, 1'b1, 1'b1, 1'b0);
        measure_window(padded_ref(16'h8000, 1'b1, 1'b0), padded_ref(16'h7fff, 1'b1, 1'b0),
                       SETTLE, "signed extremes");

        apply_inputs($random(seed), $random(seed), 1'b1, 1'b1, 1'b1);
        measure_window(padded_ref('0, 1'b0, 1'b1), padded_ref('0, 1'b0, 1'b1), SETTLE,
                       "muted while running");
        st = dut0.u_ctrl.state;
        check_level(1'b1, st == snd_ctrl_pkg::ST_MUTE, "controller in mute state");
        show_state("during mute");
        apply_inputs(smp_l[0], smp_r[0], 1'b1, 1'b1, 1'b0);
        measure_window(padded_ref(smp_l[0], 1'b1, 1'b0), padded_ref(smp_r[0], 1'b1, 1'b0),
                       SETTLE_LONG, "after mute release");

        // fresh reset so both accumulators share one history
        apply_inputs(smp_l[1], ~smp_l[1], 1'b0, 1'b0, 1'b0);
        reset_dut();
        mono_chk = 1'b1;
        measure_window(padded_ref(smp_l[1], 1'b0, 1'b0), padded_ref(smp_l[1], 1'b0, 1'b0),
                       SETTLE_LONG, "mono");
        @(posedge clk_dac);
        mono_chk = 1'b0;
        show_state("end of run");

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
